// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_fe_top
RTL_TOP   ?= fe_top
FLIST     ?= vlog.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(MDIR) -o V$(TB_TOP)
	./$(MDIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(MDIR) $(LOG)

// File: fe_fetch_ctrl.sv
`timescale 1ns/100ps

module fe_fetch_ctrl
  import fe_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_commit_valid,
  input  trap_cause_t              i_commit_cause,
  input  vaddr_t                   i_commit_epc,
  input  vaddr_t                   i_mtvec,
  input  vaddr_t                   i_stvec,
  input  vaddr_t                   i_mepc,
  input  vaddr_t                   i_sepc,
  input  logic [31:0]              i_medeleg,
  input  logic                     i_br_mispredict,
  input  vaddr_t                   i_br_vaddr,
  input  logic                     i_fence_i,
  input  logic                     i_s2_valid,
  input  logic                     i_s2_miss,
  input  logic                     i_fill_done,
  input  logic                     i_buf_ready,
  output logic                     o_s0_req,
  output vaddr_t                   o_s0_vaddr,
  output logic                     o_flush,
  output logic [LINE_OFFSET_W-1:0] o_redirect_offset,
  output logic                     o_s2_valid,
  output vaddr_t                   o_s2_vaddr
);

fetch_state_t r_state;
fetch_state_t w_state_next;
vaddr_t       r_s0_vaddr;
vaddr_t       w_s0_vaddr;
vaddr_t       w_s0_vaddr_next;
logic         w_s0_req;
logic         r_s1_valid;
vaddr_t       r_s1_vaddr;
logic         r_s2_valid;
vaddr_t       r_s2_vaddr;

logic         w_flush;
vaddr_t       w_trap_vaddr;
vaddr_t       w_flush_vaddr;
logic         w_s2_miss;
logic         w_s2_full;
logic         w_kill;

// ==========================================================================
// redirect target
// ==========================================================================
always_comb begin
  if (i_medeleg[i_commit_cause]) begin
    w_trap_vaddr = i_stvec;
  end else begin
    w_trap_vaddr = i_mtvec;
  end
  case (i_commit_cause)
    SILENT_FLUSH : w_trap_vaddr = i_commit_epc + 32'd4;
    MRET         : w_trap_vaddr = i_mepc;
    SRET         : w_trap_vaddr = i_sepc;
    default      : begin end
  endcase
end

always_comb begin
  if (i_commit_valid) begin
    w_flush_vaddr = w_trap_vaddr;  // commit beats branch
  end else if (i_br_mispredict) begin
    w_flush_vaddr = i_br_vaddr;
  end else begin
    w_flush_vaddr = next_line(r_s0_vaddr);  // fence.i alone
  end
end

assign w_flush    = i_commit_valid | i_br_mispredict | i_fence_i;
assign w_s0_vaddr = w_flush ? w_flush_vaddr : r_s0_vaddr;
assign w_s2_miss  = i_s2_miss;
assign w_s2_full  = i_s2_valid & ~i_buf_ready;

// ==========================================================================
// fetch FSM
// ==========================================================================
always_comb begin
  w_state_next    = r_state;
  w_s0_vaddr_next = r_s0_vaddr;
  w_s0_req        = 1'b0;
  case (r_state)
    ST_INIT, ST_ISSUED : begin
      if (w_s2_miss) begin
        w_state_next    = ST_WAIT_FILL;
        w_s0_vaddr_next = r_s2_vaddr;  // retry after refill
      end else if (w_s2_full) begin
        w_state_next    = ST_WAIT_BUF;
        w_s0_vaddr_next = r_s2_vaddr;
      end else begin
        w_s0_req        = 1'b1;
        w_state_next    = ST_ISSUED;
        w_s0_vaddr_next = next_line(w_s0_vaddr);
      end
    end
    ST_WAIT_FILL : begin
      if (i_fill_done) begin
        w_state_next = ST_ISSUED;
      end
    end
    ST_WAIT_BUF : begin
      if (i_buf_ready) begin
        w_s0_req        = 1'b1;
        w_state_next    = ST_ISSUED;
        w_s0_vaddr_next = next_line(w_s0_vaddr);
      end
    end
    default : begin end
  endcase

  if (w_flush) begin
    if (r_state == ST_WAIT_FILL) begin
      w_s0_vaddr_next = w_flush_vaddr;  // refill still owns the cache
    end else begin
      w_s0_req        = 1'b1;
      w_state_next    = ST_ISSUED;
      w_s0_vaddr_next = next_line(w_flush_vaddr);
    end
  end
end

assign w_kill = w_flush | w_s2_miss | w_s2_full;

always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_state    <= ST_INIT;
    r_s0_vaddr <= PC_INIT_VAL;
    r_s1_valid <= 1'b0;
    r_s2_valid <= 1'b0;
  end else begin
    r_state    <= w_state_next;
    r_s0_vaddr <= w_s0_vaddr_next;
    r_s1_valid <= w_s0_req;
    r_s2_valid <= r_s1_valid & ~w_kill;
  end
end

always_ff @(posedge i_clk) begin
  r_s1_vaddr <= w_s0_vaddr;
  r_s2_vaddr <= r_s1_vaddr;
end

assign o_s0_req          = w_s0_req;
assign o_s0_vaddr        = w_s0_vaddr;
assign o_flush           = w_flush;
assign o_redirect_offset = w_flush_vaddr[LINE_OFFSET_W-1:0];
assign o_s2_valid        = r_s2_valid;
assign o_s2_vaddr        = r_s2_vaddr;

endmodule

// File: fe_icache_refill.sv
`timescale 1ns/100ps

module fe_icache_refill
  import fe_pkg::*;
#(
  parameter int NUM_WAYS = 2
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  input  logic                 i_s2_valid_in,
  input  vaddr_t               i_s2_vaddr_in,
  input  logic [NUM_WAYS-1:0]  i_way_hit,
  input  line_t [NUM_WAYS-1:0] i_way_line,
  input  logic                 i_l2_resp_valid,
  input  line_t                i_l2_resp_data,
  output logic                 o_l2_req_valid,
  output vaddr_t               o_l2_req_addr,
  output logic [NUM_WAYS-1:0]  o_fill_we,
  output vaddr_t               o_fill_vaddr,
  output line_t                o_fill_line,
  output logic                 o_fill_done,
  output logic                 o_s2_valid,
  output logic                 o_s2_miss,
  output line_t                o_s2_line,
  output vaddr_t               o_s2_vaddr
);

localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

logic             w_any_hit;
line_t            w_hit_line;
logic             w_live;
logic             w_miss_start;
logic             w_resp_take;

logic             r_busy;
logic             r_req_valid;
logic             r_fill_pending;
logic [WAY_W-1:0] r_victim;
vaddr_t           r_miss_vaddr;
line_t            r_fill_line;

// ==========================================================================
// hit merge
// ==========================================================================
always_comb begin
  w_hit_line = '0;
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (i_way_hit[w]) begin
      w_hit_line = w_hit_line | i_way_line[w];
    end
  end
end

assign w_any_hit    = |i_way_hit;
assign w_live       = i_s2_valid_in & ~i_flush;  // drop stale responses
assign w_miss_start = w_live & ~w_any_hit & ~r_busy;
assign w_resp_take  = i_l2_resp_valid & r_busy & ~r_fill_pending;

// ==========================================================================
// miss and refill
// ==========================================================================
always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_busy         <= 1'b0;
    r_req_valid    <= 1'b0;
    r_fill_pending <= 1'b0;
    r_victim       <= '0;
  end else begin
    r_req_valid <= w_miss_start;
    if (w_miss_start) begin
      r_busy <= 1'b1;
    end else if (r_fill_pending) begin
      r_busy <= 1'b0;
    end
    r_fill_pending <= w_resp_take;
    if (r_fill_pending) begin
      r_victim <= (r_victim == WAY_W'(NUM_WAYS - 1)) ? '0 : r_victim + 1'b1;
    end
  end
end

always_ff @(posedge i_clk) begin
  if (w_miss_start) begin
    r_miss_vaddr <= i_s2_vaddr_in;
  end
  if (w_resp_take) begin
    r_fill_line <= i_l2_resp_data;
  end
end

always_comb begin
  for (int w = 0; w < NUM_WAYS; w++) begin
    o_fill_we[w] = r_fill_pending & (r_victim == WAY_W'(w));
  end
end

assign o_l2_req_valid = r_req_valid;
assign o_l2_req_addr  = line_base(r_miss_vaddr);
assign o_fill_vaddr   = line_base(r_miss_vaddr);
assign o_fill_line    = r_fill_line;
assign o_fill_done    = r_fill_pending;
assign o_s2_valid     = w_live & w_any_hit;
assign o_s2_miss      = w_live & ~w_any_hit;
assign o_s2_line      = w_hit_line;
assign o_s2_vaddr     = i_s2_vaddr_in;

endmodule

// File: fe_icache_way.sv
`timescale 1ns/100ps

module fe_icache_way
  import fe_pkg::*;
#(
  parameter int NUM_SETS = 16
) (
  input  logic   i_clk,
  input  logic   i_reset_n,
  input  logic   i_invalidate,
  input  logic   i_s0_req,
  input  vaddr_t i_s0_vaddr,
  input  logic   i_fill_we,
  input  vaddr_t i_fill_vaddr,
  input  line_t  i_fill_line,
  output logic   o_s2_hit,
  output line_t  o_s2_line
);

localparam int IDX_W = $clog2(NUM_SETS);
localparam int TAG_W = VADDR_W - LINE_OFFSET_W - IDX_W;

typedef logic [TAG_W-1:0] tag_t;
typedef logic [IDX_W-1:0] idx_t;

logic [NUM_SETS-1:0] r_valid;
tag_t                r_tag  [NUM_SETS];
line_t               r_data [NUM_SETS];

idx_t  w_s0_idx;
idx_t  w_fill_idx;
logic  r_s1_req;
logic  r_s1_valid;
tag_t  r_s1_tag;
tag_t  r_s1_req_tag;
line_t r_s1_line;
logic  r_s2_hit;
line_t r_s2_line;

assign w_s0_idx   = i_s0_vaddr[LINE_OFFSET_W +: IDX_W];
assign w_fill_idx = i_fill_vaddr[LINE_OFFSET_W +: IDX_W];

always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_valid    <= '0;
    r_s1_req   <= 1'b0;
    r_s1_valid <= 1'b0;
    r_s2_hit   <= 1'b0;
  end else begin
    if (i_invalidate) begin
      r_valid <= '0;
    end
    if (i_fill_we) begin
      r_valid[w_fill_idx] <= 1'b1;  // refill lands even across fence.i
    end
    r_s1_req   <= i_s0_req;
    r_s1_valid <= r_valid[w_s0_idx] & ~i_invalidate;
    r_s2_hit   <= r_s1_req & r_s1_valid & (r_s1_tag == r_s1_req_tag);
  end
end

always_ff @(posedge i_clk) begin
  if (i_fill_we) begin
    r_tag[w_fill_idx]  <= i_fill_vaddr[VADDR_W-1 -: TAG_W];
    r_data[w_fill_idx] <= i_fill_line;
  end
  r_s1_tag     <= r_tag[w_s0_idx];
  r_s1_req_tag <= i_s0_vaddr[VADDR_W-1 -: TAG_W];
  r_s1_line    <= r_data[w_s0_idx];
  r_s2_line    <= r_s1_line;
end

assign o_s2_hit  = r_s2_hit;
assign o_s2_line = r_s2_line;

endmodule

// File: fe_inst_buffer.sv
`timescale 1ns/100ps

module fe_inst_buffer
  import fe_pkg::*;
#(
  parameter int BUF_DEPTH = 4
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_flush,
  input  logic [LINE_OFFSET_W-1:0] i_redirect_offset,
  input  logic                     i_load,
  input  line_t                    i_line,
  input  vaddr_t                   i_line_vaddr,
  output logic                     o_ready,
  output logic                     o_disp_valid,
  output vaddr_t                   o_disp_pc,
  output inst_t                    o_disp_inst,
  input  logic                     i_disp_ready
);

localparam int PTR_W  = $clog2(BUF_DEPTH);
localparam int CNT_W  = PTR_W + 1;
localparam int WORD_W = LINE_OFFSET_W - 2;

line_t             r_line  [BUF_DEPTH];
vaddr_t            r_vaddr [BUF_DEPTH];
logic [PTR_W-1:0]  r_rd_ptr;
logic [PTR_W-1:0]  r_wr_ptr;
logic [CNT_W-1:0]  r_count;
logic [WORD_W-1:0] r_word;  // word index within head line

logic w_push;
logic w_pop;
logic w_pop_line;

assign o_ready      = (r_count < CNT_W'(BUF_DEPTH));
assign o_disp_valid = (r_count != '0);
assign w_push       = i_load & o_ready & ~i_flush;
assign w_pop        = o_disp_valid & i_disp_ready;
assign w_pop_line   = w_pop & (r_word == '1);

always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_rd_ptr <= '0;
    r_wr_ptr <= '0;
    r_count  <= '0;
    r_word   <= '0;
  end else if (i_flush) begin
    r_rd_ptr <= '0;
    r_wr_ptr <= '0;
    r_count  <= '0;
    // first line of the new stream starts at the target word
    r_word   <= i_redirect_offset[LINE_OFFSET_W-1:2];
  end else begin
    if (w_push) begin
      r_wr_ptr <= r_wr_ptr + 1'b1;
    end
    if (w_pop_line) begin
      r_rd_ptr <= r_rd_ptr + 1'b1;
      r_word   <= '0;
    end else if (w_pop) begin
      r_word <= r_word + 1'b1;
    end
    r_count <= r_count + CNT_W'(w_push) - CNT_W'(w_pop_line);
  end
end

always_ff @(posedge i_clk) begin
  if (w_push) begin
    r_line[r_wr_ptr]  <= i_line;
    r_vaddr[r_wr_ptr] <= i_line_vaddr;
  end
end

assign o_disp_pc   = {r_vaddr[r_rd_ptr][VADDR_W-1:LINE_OFFSET_W], r_word, 2'b00};
assign o_disp_inst = r_line[r_rd_ptr][r_word * INST_W +: INST_W];

endmodule

// File: fe_pkg.sv
package fe_pkg;

// ==========================================================================
// widths and types
// ==========================================================================
localparam int VADDR_W       = 32;
localparam int INST_W        = 32;
localparam int LINE_BYTES    = 16;
localparam int LINE_W        = LINE_BYTES * 8;
localparam int LINE_OFFSET_W = $clog2(LINE_BYTES);

typedef logic [VADDR_W-1:0] vaddr_t;
typedef logic [INST_W-1:0]  inst_t;
typedef logic [LINE_W-1:0]  line_t;  // word 0 in the low bits

localparam vaddr_t PC_INIT_VAL = 32'h0000_1000;

// standard mcause numbers where one exists
typedef enum logic [4:0] {
  INST_ACC_FAULT  = 5'd1,
  ILLEGAL_INST    = 5'd2,
  LOAD_ACC_FAULT  = 5'd5,
  STORE_ACC_FAULT = 5'd7,
  ECALL_U         = 5'd8,
  ECALL_S         = 5'd9,
  ECALL_M         = 5'd11,
  SILENT_FLUSH    = 5'd16,
  MRET            = 5'd17,
  SRET            = 5'd18
} trap_cause_t;

typedef enum logic [1:0] {
  ST_INIT      = 2'd0,
  ST_ISSUED    = 2'd1,
  ST_WAIT_FILL = 2'd2,
  ST_WAIT_BUF  = 2'd3
} fetch_state_t;

function automatic vaddr_t line_base(input vaddr_t a);
  line_base = {a[VADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
endfunction

function automatic vaddr_t next_line(input vaddr_t a);
  next_line = line_base(a) + vaddr_t'(LINE_BYTES);
endfunction

endpackage

// File: fe_top.sv
`timescale 1ns/100ps

module fe_top
  import fe_pkg::*;
#(
  parameter int NUM_WAYS  = 2,
  parameter int NUM_SETS  = 16,
  parameter int BUF_DEPTH = 4
) (
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  logic        i_commit_valid,
  input  trap_cause_t i_commit_cause,
  input  vaddr_t      i_commit_epc,
  input  vaddr_t      i_mtvec,
  input  vaddr_t      i_stvec,
  input  vaddr_t      i_mepc,
  input  vaddr_t      i_sepc,
  input  logic [31:0] i_medeleg,
  input  logic        i_br_mispredict,
  input  vaddr_t      i_br_vaddr,
  input  logic        i_fence_i,
  output logic        o_l2_req_valid,
  output vaddr_t      o_l2_req_addr,
  input  logic        i_l2_resp_valid,
  input  line_t       i_l2_resp_data,
  output logic        o_disp_valid,
  output vaddr_t      o_disp_pc,
  output inst_t       o_disp_inst,
  input  logic        i_disp_ready
);

logic                     w_s0_req;
vaddr_t                   w_s0_vaddr;
logic                     w_flush;
logic [LINE_OFFSET_W-1:0] w_redirect_offset;
logic                     w_s2_req_valid;  // controller side of s2
vaddr_t                   w_s2_req_vaddr;
logic                     w_s2_valid;
logic                     w_s2_miss;
line_t                    w_s2_line;
vaddr_t                   w_s2_vaddr;
logic                     w_fill_done;
logic                     w_buf_ready;
logic [NUM_WAYS-1:0]      w_fill_we;
vaddr_t                   w_fill_vaddr;
line_t                    w_fill_line;
logic [NUM_WAYS-1:0]      w_way_hit;
line_t [NUM_WAYS-1:0]     w_way_line;

fe_fetch_ctrl u_fetch_ctrl (
  .i_clk             (i_clk),
  .i_reset_n         (i_reset_n),
  .i_commit_valid    (i_commit_valid),
  .i_commit_cause    (i_commit_cause),
  .i_commit_epc      (i_commit_epc),
  .i_mtvec           (i_mtvec),
  .i_stvec           (i_stvec),
  .i_mepc            (i_mepc),
  .i_sepc            (i_sepc),
  .i_medeleg         (i_medeleg),
  .i_br_mispredict   (i_br_mispredict),
  .i_br_vaddr        (i_br_vaddr),
  .i_fence_i         (i_fence_i),
  .i_s2_valid        (w_s2_valid),
  .i_s2_miss         (w_s2_miss),
  .i_fill_done       (w_fill_done),
  .i_buf_ready       (w_buf_ready),
  .o_s0_req          (w_s0_req),
  .o_s0_vaddr        (w_s0_vaddr),
  .o_flush           (w_flush),
  .o_redirect_offset (w_redirect_offset),
  .o_s2_valid        (w_s2_req_valid),
  .o_s2_vaddr        (w_s2_req_vaddr)
);

// ==========================================================================
// cache ways sharing one lookup address
// ==========================================================================
for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
  fe_icache_way #(
    .NUM_SETS (NUM_SETS)
  ) u_way (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_invalidate (i_fence_i),
    .i_s0_req     (w_s0_req),
    .i_s0_vaddr   (w_s0_vaddr),
    .i_fill_we    (w_fill_we[w]),
    .i_fill_vaddr (w_fill_vaddr),
    .i_fill_line  (w_fill_line),
    .o_s2_hit     (w_way_hit[w]),
    .o_s2_line    (w_way_line[w])
  );
end

fe_icache_refill #(
  .NUM_WAYS (NUM_WAYS)
) u_refill (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_flush         (w_flush),
  .i_s2_valid_in   (w_s2_req_valid),
  .i_s2_vaddr_in   (w_s2_req_vaddr),
  .i_way_hit       (w_way_hit),
  .i_way_line      (w_way_line),
  .i_l2_resp_valid (i_l2_resp_valid),
  .i_l2_resp_data  (i_l2_resp_data),
  .o_l2_req_valid  (o_l2_req_valid),
  .o_l2_req_addr   (o_l2_req_addr),
  .o_fill_we       (w_fill_we),
  .o_fill_vaddr    (w_fill_vaddr),
  .o_fill_line     (w_fill_line),
  .o_fill_done     (w_fill_done),
  .o_s2_valid      (w_s2_valid),
  .o_s2_miss       (w_s2_miss),
  .o_s2_line       (w_s2_line),
  .o_s2_vaddr      (w_s2_vaddr)
);

fe_inst_buffer #(
  .BUF_DEPTH (BUF_DEPTH)
) u_inst_buffer (
  .i_clk             (i_clk),
  .i_reset_n         (i_reset_n),
  .i_flush           (w_flush),
  .i_redirect_offset (w_redirect_offset),
  .i_load            (w_s2_valid),
  .i_line            (w_s2_line),
  .i_line_vaddr      (w_s2_vaddr),
  .o_ready           (w_buf_ready),
  .o_disp_valid      (o_disp_valid),
  .o_disp_pc         (o_disp_pc),
  .o_disp_inst       (o_disp_inst),
  .i_disp_ready      (i_disp_ready)
);

endmodule

// File: tb_fe_top.sv
`timescale 1ns/100ps

module tb_fe_top
  import fe_pkg::*;
();

localparam int     RESET_CYC    = 10;
localparam int     IDLE_LIMIT   = 100;
localparam int     TOTAL_INSTR  = 32 + 48 + 4 * 12 + 8 * 8 + 2 * 8 + 8;
localparam int     WATCHDOG_CYC = (TOTAL_INSTR + RESET_CYC) * 20;
localparam vaddr_t LINE_MASK    = 32'hffff_fff0;

logic        i_clk;
logic        i_reset_n;
logic        i_commit_valid;
trap_cause_t i_commit_cause;
vaddr_t      i_commit_epc;
vaddr_t      i_mtvec;
vaddr_t      i_stvec;
vaddr_t      i_mepc;
vaddr_t      i_sepc;
logic [31:0] i_medeleg;
logic        i_br_mispredict;
vaddr_t      i_br_vaddr;
logic        i_fence_i;
logic        o_l2_req_valid;
vaddr_t      o_l2_req_addr;
logic        i_l2_resp_valid;
line_t       i_l2_resp_data;
logic        o_disp_valid;
vaddr_t      o_disp_pc;
inst_t       o_disp_inst;
logic        i_disp_ready;

logic [31:0] seed;
logic [31:0] l2_seed;
vaddr_t      exp_pc;          // next pc expected at dispatch
vaddr_t      req_log [$];     // every L2 line request seen
int          errors;
int          l2_errors;
int          checks;
int          tests_run;
int          tests_failed;
int          test_err0;
string       test_name;
trap_cause_t causes [8] = '{ECALL_U, ECALL_S, ECALL_M, ILLEGAL_INST,
                            LOAD_ACC_FAULT, MRET, SRET, SILENT_FLUSH};

fe_top u_fe_top (.*);

// ==========================================================================
// helpers
// ==========================================================================
function automatic logic [31:0] lcg_step(input logic [31:0] s);
  lcg_step = s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic vaddr_t word_addr(input logic [31:0] r);
  word_addr = 32'h0000_1000 + {20'h0, r[25:16], 2'b00};  // 0x1000..0x1ffc
endfunction

// memory contents as a hash of the full address
function automatic inst_t inst_at(input vaddr_t a);
  inst_at = (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h1357_9bdf;
endfunction

function automatic line_t line_at(input vaddr_t base);
  for (int i = 0; i < 4; i++) begin
    line_at[i*32 +: 32] = inst_at(base + vaddr_t'(4 * i));
  end
endfunction

function automatic vaddr_t trap_target(input trap_cause_t c, input vaddr_t epc,
                                       input logic [31:0] deleg);
  case (c)
    SILENT_FLUSH : trap_target = epc + 32'd4;
    MRET         : trap_target = i_mepc;
    SRET         : trap_target = i_sepc;
    default      : trap_target = deleg[c] ? i_stvec : i_mtvec;
  endcase
endfunction

function automatic int count_requests(input int from, input vaddr_t line);
  count_requests = 0;
  for (int i = from; i < req_log.size(); i++) begin
    if (req_log[i] == line) begin
      count_requests++;
    end
  end
endfunction

function automatic int total_errors();
  total_errors = errors + l2_errors;
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
  checks++;
  if (got !== exp) begin
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic start_test(input string name);
  test_name = name;
  test_err0 = total_errors();
  tests_run++;
endtask

task automatic end_test();
  if (total_errors() == test_err0) begin
    $display("test %0d %s: ok", tests_run, test_name);
  end else begin
    tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, test_name, total_errors() - test_err0);
  end
endtask

// take n instructions from dispatch with optional random stalls
task automatic run_stream(input int n, input logic backpress);
  int   got;
  int   idle;
  logic rdy;
  got  = 0;
  idle = 0;
  while (got < n && idle < IDLE_LIMIT) begin
    @(negedge i_clk);
    seed         = lcg_step(seed);
    rdy          = !backpress || (seed[17:16] != 2'b00);
    i_disp_ready = rdy;
    if (o_disp_valid && rdy) begin
      check_eq(o_disp_pc, exp_pc, "dispatch pc");
      check_eq(o_disp_inst, inst_at(exp_pc), "dispatch inst");
      exp_pc = exp_pc + 32'd4;
      got++;
      idle = 0;
    end else begin
      idle++;
    end
  end
  if (got < n) begin
    $display("no instruction dispatched for %0d cycles at %0t ns, got %0d of %0d",
             IDLE_LIMIT, $time, got, n);
    errors++;
  end
endtask

task automatic mispredict_to(input vaddr_t t);
  @(negedge i_clk);
  i_disp_ready    = 1'b0;
  i_br_mispredict = 1'b1;
  i_br_vaddr      = t;
  @(negedge i_clk);
  i_br_mispredict = 1'b0;
  exp_pc          = t;
endtask

task automatic trap_to(input trap_cause_t c, input logic deleg_bit);
  vaddr_t t;
  @(negedge i_clk);
  seed            = lcg_step(seed);
  i_medeleg       = seed;
  i_medeleg[c]    = deleg_bit;
  seed            = lcg_step(seed);
  i_commit_epc    = word_addr(seed);
  i_disp_ready    = 1'b0;
  i_commit_valid  = 1'b1;
  i_commit_cause  = c;
  t               = trap_target(c, i_commit_epc, i_medeleg);
  i_br_mispredict = 1'b1;  // same cycle and loses to the trap
  i_br_vaddr      = t ^ 32'h0000_0040;
  @(negedge i_clk);
  i_commit_valid  = 1'b0;
  i_br_mispredict = 1'b0;
  exp_pc          = t;
endtask

task automatic fence_pulse();
  @(negedge i_clk);
  i_disp_ready = 1'b0;
  i_fence_i    = 1'b1;
  @(negedge i_clk);
  i_fence_i    = 1'b0;
endtask

// ==========================================================================
// clock, L2 model, watchdog
// ==========================================================================
initial begin : clock_gen
  i_clk = 1'b0;
  forever #2 i_clk = ~i_clk;
end

initial begin : l2_model
  logic   pending;
  vaddr_t addr;
  int     wait_cyc;
  pending         = 1'b0;
  addr            = '0;
  wait_cyc        = 0;
  l2_errors       = 0;
  l2_seed         = lcg_step(32'd9);
  i_l2_resp_valid = 1'b0;
  i_l2_resp_data  = '0;
  forever begin
    @(negedge i_clk);
    i_l2_resp_valid = 1'b0;
    if (pending) begin
      if (wait_cyc == 0) begin
        i_l2_resp_valid = 1'b1;
        i_l2_resp_data  = line_at(addr);
        pending         = 1'b0;
      end else begin
        wait_cyc--;
      end
    end
    if (i_reset_n && o_l2_req_valid) begin
      if (pending) begin
        $display("L2 request for %h at %0t ns while another is outstanding",
                 o_l2_req_addr, $time);
        l2_errors++;
      end
      req_log.push_back(o_l2_req_addr);
      pending  = 1'b1;
      addr     = o_l2_req_addr;
      l2_seed  = lcg_step(l2_seed);
      wait_cyc = int'(l2_seed[18:16]);  // 1 to 8 cycles
    end
  end
end

initial begin : watchdog
  repeat (WATCHDOG_CYC) @(posedge i_clk);
  $display("run did not finish within %0d cycles", WATCHDOG_CYC);
  $display("RESULT: FAIL");
  $finish;
end

// ==========================================================================
// test sequence
// ==========================================================================
initial begin : main
  int     line_mark;
  vaddr_t t;
  seed            = 32'd9;
  errors          = 0;
  checks          = 0;
  tests_run       = 0;
  tests_failed    = 0;
  i_reset_n       = 1'b0;
  i_commit_valid  = 1'b0;
  i_commit_cause  = SILENT_FLUSH;
  i_commit_epc    = '0;
  i_medeleg       = '0;
  i_br_mispredict = 1'b0;
  i_br_vaddr      = '0;
  i_fence_i       = 1'b0;
  i_disp_ready    = 1'b0;
  seed            = lcg_step(seed);
  i_mtvec         = word_addr(seed);
  seed            = lcg_step(seed);
  i_stvec         = word_addr(seed);
  seed            = lcg_step(seed);
  i_mepc          = word_addr(seed);
  seed            = lcg_step(seed);
  i_sepc          = word_addr(seed);
  exp_pc          = PC_INIT_VAL;

  start_test("reset and sequential fetch");
  repeat (RESET_CYC) @(negedge i_clk);
  check_eq(o_l2_req_valid, 1'b0, "l2 request in reset");
  check_eq(o_disp_valid, 1'b0, "dispatch valid in reset");
  i_reset_n = 1'b1;
  run_stream(32, 1'b0);
  end_test();

  start_test("dispatch back-pressure");
  run_stream(48, 1'b1);
  end_test();

  start_test("branch mispredict");
  repeat (4) begin
    seed = lcg_step(seed);
    mispredict_to(word_addr(seed));  // often mid-line
    run_stream(12, 1'b1);
  end
  end_test();

  start_test("trap redirect");
  for (int k = 0; k < 8; k++) begin
    trap_to(causes[k], k[0]);
    run_stream(8, 1'b1);
  end
  end_test();

  start_test("cache hit on refetch");
  seed = lcg_step(seed);
  t    = word_addr(seed);
  mispredict_to(t);
  run_stream(8, 1'b1);
  line_mark = req_log.size();
  mispredict_to(t);
  run_stream(8, 1'b1);
  check_eq(count_requests(line_mark, t & LINE_MASK), 0, "L2 requests for a cached line");
  end_test();

  start_test("fence.i invalidate");
  line_mark = req_log.size();
  fence_pulse();
  mispredict_to(t);
  run_stream(8, 1'b1);
  check_eq(count_requests(line_mark, t & LINE_MASK) != 0, 1'b1, "L2 refetch after fence.i");
  end_test();

  $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
           tests_run, tests_run - tests_failed, tests_failed, checks, total_errors());
  if (total_errors() == 0) begin
    $display("RESULT: PASS");
  end else begin
    $display("RESULT: FAIL");
  end
  $finish;
end

endmodule

// File: vlog.f
fe_pkg.sv
fe_fetch_ctrl.sv
fe_icache_way.sv
fe_icache_refill.sv
fe_inst_buffer.sv
fe_top.sv
tb_fe_top.sv
